/* src.f */
logic/mipsPkg.sv
logic/hazardIf.sv
logic/pipeControl.sv
logic/fetchUnit.sv
logic/regFile.sv
logic/executeUnit.sv
logic/mipsCore.sv
sim/mipsCore_assertions.sv
sim/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module mipsCoreTb \
	-o mipsCoreSim > build.log 2>&1 \
	&& ./obj_dir/mipsCoreSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "run ok" || { echo "run failed"; exit 1; }

/* sim/mipsCoreTb.sv */
`timescale 1ns/10ps

module mipsCoreTb import mipsPkg::*; ();
	localparam int wbTimeout = 100;

	logic clk;
	logic arstN;
	logic [31:0] pcF;
	logic [31:0] instrF;
	logic memWriteM;
	logic [3:0] byteEnM;
	logic [31:0] aluOutM;
	logic [31:0] writeDataM;
	logic [31:0] readDataM;
	logic [31:0] debugWbPc;
	logic [3:0] debugWbRfWen;
	logic [4:0] debugWbRfWnum;
	logic [31:0] debugWbRfWdata;

	// memories and program image
	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] expMem [256];
	logic [7:0] testOf [256];
	int ptr;
	int curTest;
	logic [31:0] endPc;
	integer seed;
	// expected writeback trace
	logic [31:0] expPc [$];
	logic [4:0] expReg [$];
	logic [31:0] expData [$];
	int expTest [$];
	logic [31:0] firstStoreAddr;
	logic storeSeen;
	int testFails [7];
	logic timedOut;

	mipsCore u_dut (
		.clk(clk), .arstN(arstN), .pcF(pcF), .instrF(instrF), .memWriteM(memWriteM),
		.byteEnM(byteEnM), .aluOutM(aluOutM), .writeDataM(writeDataM),
		.readDataM(readDataM), .debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// memories
	//////////////////////////////////////////////////
	always @(posedge clk) begin
		if (memWriteM) begin
			for (int k = 0; k < 4; k++)
				if (byteEnM[k])
					dmem[aluOutM[9:2]][8*k +: 8] <= writeDataM[8*k +: 8];
		end
		#1;
		instrF = imem[pcF[9:2]];
		readDataM = dmem[aluOutM[9:2]];
	end

	// first store must be the model's first store
	always @(negedge clk) begin
		if (arstN && memWriteM && !storeSeen) begin
			storeSeen = 1'b1;
			assert (aluOutM == firstStoreAddr) else begin
				$display("FAIL first store: expected address %h, actual %h",
					firstStoreAddr, aluOutM);
				testFails[6]++;
			end
		end
	end

	//////////////////////////////////////////////////
	// program building
	//////////////////////////////////////////////////
	task automatic emit(input logic [31:0] w);
		imem[ptr] = w;
		testOf[ptr] = 8'(curTest);
		ptr++;
	endtask

	function automatic logic [31:0] rInstr(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jInstr(input logic [5:0] op, input logic [31:0] target);
		return {op, target[27:2]};
	endfunction

	function automatic logic [15:0] rnd16();
		return 16'($random(seed));
	endfunction

	task automatic buildProgram();
		logic [31:0] a;
		ptr = 0;
		// dependent alu chains
		curTest = 1;
		for (int k = 0; k < 6; k++) begin
			emit(iInstr(opOri, 0, 1, rnd16()));
			emit(iInstr(opAddiu, 0, 2, rnd16()));
			emit(rInstr(fnAddu, 1, 2, 3));
			emit(rInstr(fnSubu, 3, 1, 4));
			emit(rInstr(fnAnd, 4, 3, 5));
			emit(rInstr(fnOr, 5, 2, 6));
			emit(rInstr(fnSlt, 6, 3, 7));
			emit(rInstr(fnSlt, 2, 1, 8));
			emit(iInstr(opAddiu, 7, 9, rnd16()));
			emit(iInstr(opOri, 9, 10, rnd16()));
			// write to r0 then read it right away
			emit(iInstr(opAddiu, 10, 0, rnd16()));
			emit(rInstr(fnOr, 0, 10, 8));
		end
		// load then use
		curTest = 2;
		emit(iInstr(opLw, 0, 11, 16));
		emit(rInstr(fnAddu, 11, 1, 12));
		emit(iInstr(opLw, 0, 13, 20));
		emit(rInstr(fnAddu, 13, 13, 14));
		emit(rInstr(fnSubu, 14, 11, 15));
		// branches, delay slots
		curTest = 3;
		emit(iInstr(opLw, 0, 16, 24));
		emit(iInstr(opBeq, 16, 16, 2));
		emit(iInstr(opAddiu, 0, 17, 1));
		emit(iInstr(opAddiu, 0, 17, 2));
		emit(iInstr(opAddiu, 0, 18, 3));
		emit(iInstr(opBne, 18, 17, 2));
		emit(iInstr(opAddiu, 0, 19, 4));
		emit(iInstr(opAddiu, 0, 19, 5));
		emit(iInstr(opBeq, 18, 17, 2));
		emit(iInstr(opAddiu, 0, 20, 6));
		emit(iInstr(opAddiu, 20, 20, 7));
		emit(iInstr(opBne, 18, 18, 2));
		emit(iInstr(opAddiu, 0, 21, 8));
		emit(iInstr(opAddiu, 21, 21, 9));
		// call and return
		curTest = 4;
		a = 32'(ptr * 4);
		emit(jInstr(opJal, a + 32'd20));
		emit(iInstr(opAddiu, 0, 22, 10));
		emit(iInstr(opAddiu, 0, 23, 11));
		emit(jInstr(opJ, a + 32'd32));
		emit(iInstr(opAddiu, 0, 24, 12));
		emit(iInstr(opAddiu, 31, 25, 4));
		emit(rInstr(fnJr, 31, 0, 0));
		emit(iInstr(opAddiu, 25, 26, 1));
		emit(iInstr(opAddiu, 0, 27, 13));
		// hi/lo
		curTest = 5;
		emit(iInstr(opAddiu, 0, 1, rnd16()));
		emit(iInstr(opOri, 0, 2, rnd16()));
		emit(rInstr(fnMult, 1, 2, 0));
		emit(rInstr(fnMfhi, 0, 0, 3));
		emit(rInstr(fnMflo, 0, 0, 4));
		emit(iInstr(opAddiu, 0, 5, 16'h8000 | rnd16()));
		emit(rInstr(fnMult, 5, 1, 0));
		emit(rInstr(fnMflo, 0, 0, 6));
		emit(rInstr(fnMfhi, 0, 0, 7));
		// stores and readback
		curTest = 6;
		emit(iInstr(opAddiu, 0, 1, rnd16()));
		emit(iInstr(opOri, 0, 2, rnd16()));
		emit(iInstr(opSw, 0, 1, 64));
		emit(iInstr(opSb, 0, 2, 65));
		emit(iInstr(opSb, 0, 2, 71));
		emit(iInstr(opSw, 0, 2, 68));
		emit(iInstr(opSb, 0, 1, 68));
		emit(iInstr(opSb, 0, 1, 75));
		emit(iInstr(opLw, 0, 3, 64));
		emit(iInstr(opLw, 0, 4, 68));
		emit(iInstr(opLw, 0, 5, 72));
		// park in a self loop
		endPc = 32'(ptr * 4);
		emit(jInstr(opJ, endPc));
		emit(32'd0);
	endtask

	//////////////////////////////////////////////////
	// in-order ISA model
	//////////////////////////////////////////////////
	task automatic runModel();
		logic [31:0] mReg [32];
		logic [31:0] mHi;
		logic [31:0] mLo;
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nn;
		logic [31:0] w;
		logic [31:0] sImm;
		logic [31:0] addr;
		logic [31:0] wval;
		logic [4:0] wreg;
		logic wr;
		logic signed [63:0] a64;
		logic signed [63:0] b64;
		logic signed [63:0] prod;
		int steps;
		for (int k = 0; k < 32; k++)
			mReg[k] = 32'd0;
		mHi = 32'd0;
		mLo = 32'd0;
		pc = 32'd0;
		npc = 32'd4;
		steps = 0;
		storeSeen = 1'b0;
		firstStoreAddr = 32'hffff_ffff;
		while (pc != endPc && steps < 2000) begin
			w = imem[pc[9:2]];
			sImm = {{16{w[15]}}, w[15:0]};
			addr = mReg[w[25:21]] + sImm;
			nn = npc + 32'd4;
			wr = 1'b0;
			wreg = w[20:16];
			wval = 32'd0;
			case (w[31:26])
				opRType: begin
					wr = 1'b1;
					wreg = w[15:11];
					case (w[5:0])
						fnAddu: wval = mReg[w[25:21]] + mReg[w[20:16]];
						fnSubu: wval = mReg[w[25:21]] - mReg[w[20:16]];
						fnAnd: wval = mReg[w[25:21]] & mReg[w[20:16]];
						fnOr: wval = mReg[w[25:21]] | mReg[w[20:16]];
						fnSlt: wval = {31'd0,
							$signed(mReg[w[25:21]]) < $signed(mReg[w[20:16]])};
						fnMfhi: wval = mHi;
						fnMflo: wval = mLo;
						fnMult: begin
							wr = 1'b0;
							a64 = {{32{mReg[w[25:21]][31]}}, mReg[w[25:21]]};
							b64 = {{32{mReg[w[20:16]][31]}}, mReg[w[20:16]]};
							prod = a64 * b64;
							mHi = prod[63:32];
							mLo = prod[31:0];
						end
						fnJr: begin
							wr = 1'b0;
							nn = mReg[w[25:21]];
						end
						default: wr = 1'b0;
					endcase
				end
				opAddiu: begin
					wr = 1'b1;
					wval = addr;
				end
				opOri: begin
					wr = 1'b1;
					wval = mReg[w[25:21]] | {16'd0, w[15:0]};
				end
				opLw: begin
					wr = 1'b1;
					wval = expMem[addr[9:2]];
				end
				opSw, opSb: begin
					if (!storeSeen)
						firstStoreAddr = addr;
					storeSeen = 1'b1;
					if (w[31:26] == opSw)
						expMem[addr[9:2]] = mReg[w[20:16]];
					else
						expMem[addr[9:2]][{addr[1:0], 3'b000} +: 8] = mReg[w[20:16]][7:0];
				end
				opBeq: if (mReg[w[25:21]] == mReg[w[20:16]])
					nn = pc + 32'd4 + {sImm[29:0], 2'b00};
				opBne: if (mReg[w[25:21]] != mReg[w[20:16]])
					nn = pc + 32'd4 + {sImm[29:0], 2'b00};
				opJ, opJal: begin
					nn = {npc[31:28], w[25:0], 2'b00};
					if (w[31:26] == opJal) begin
						wr = 1'b1;
						wreg = 5'd31;
						wval = pc + 32'd8;
					end
				end
				default: wr = 1'b0;
			endcase
			if (wr && wreg != 5'd0) begin
				mReg[wreg] = wval;
				expPc.push_back(pc);
				expReg.push_back(wreg);
				expData.push_back(wval);
				expTest.push_back(int'(testOf[pc[9:2]]));
			end
			pc = npc;
			npc = nn;
			steps++;
		end
		storeSeen = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// checking
	//////////////////////////////////////////////////
	function automatic string testName(input int t);
		case (t)
			1: return "alu forwarding";
			2: return "load use";
			3: return "branches";
			4: return "jumps";
			5: return "mult hi/lo";
			default: return "stores";
		endcase
	endfunction

	task automatic reportTest(input int t);
		$display("%s: %s, %0d mismatches", testName(t), testFails[t] == 0 ? "ok" : "bad",
			testFails[t]);
	endtask

	task automatic waitWriteback(output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < wbTimeout) begin
			@(negedge clk);
			if (debugWbRfWen != 4'd0)
				seen = 1'b1;
			n++;
		end
	endtask

	initial begin
		logic seen;
		int passed;
		int failed;
		arstN = 1'b0;
		instrF = 32'd0;
		readDataM = 32'd0;
		timedOut = 1'b0;
		seed = 32'hea3c_63c9;
		for (int k = 0; k < 7; k++)
			testFails[k] = 0;
		// fill depends on every address bit
		for (int k = 0; k < 256; k++) begin
			dmem[k] = (32'(k) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
			expMem[k] = dmem[k];
			imem[k] = 32'd0;
			testOf[k] = 8'd0;
		end
		buildProgram();
		runModel();
		repeat (8) @(posedge clk);
		#1 arstN = 1'b1;

		for (int i = 0; i < expPc.size() && !timedOut; i++) begin
			waitWriteback(seen);
			if (!seen) begin
				$display("no writeback arrived for %s within %0d cycles",
					testName(expTest[i]), wbTimeout);
				timedOut = 1'b1;
			end else begin
				assert (debugWbPc == expPc[i] && debugWbRfWnum == expReg[i]
					&& debugWbRfWdata == expData[i]) else begin
					$display("FAIL %s: expected pc %h r%0d=%h, actual pc %h r%0d=%h",
						testName(expTest[i]), expPc[i], expReg[i], expData[i],
						debugWbPc, debugWbRfWnum, debugWbRfWdata);
					testFails[expTest[i]]++;
				end
				if (i + 1 < expPc.size() && expTest[i + 1] != expTest[i])
					reportTest(expTest[i]);
			end
		end

		// final memory image, stores all precede the last load
		if (!timedOut) begin
			for (int k = 0; k < 256; k++)
				assert (dmem[k] == expMem[k]) else begin
					$display("FAIL stores: word %0d expected %h, actual %h", k, expMem[k],
						dmem[k]);
					testFails[6]++;
				end
			reportTest(6);
		end

		passed = 0;
		failed = 0;
		for (int t = 1; t < 7; t++)
			if (testFails[t] == 0)
				passed++;
			else
				failed++;
		$display("%0d tests ok, %0d tests bad, %0d writebacks expected", passed, failed,
			expPc.size());
		if (!timedOut && failed == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end
endmodule

/* sim/mipsCore_assertions.sv */
`timescale 1ns/10ps

module mipsCoreAssertions (
	input logic clk,
	input logic arstN,
	input logic [31:0] pcF,
	input logic memWriteM,
	input logic [3:0] byteEnM,
	input logic [3:0] debugWbRfWen,
	input logic [4:0] debugWbRfWnum
);
	// nothing leaves the core while reset is held
	quietInReset: assert property (@(posedge clk)
		!arstN |-> (!memWriteM && debugWbRfWen == 4'd0))
		else $error("store or writeback seen during reset");

	// lanes only light up on a store
	lanesIdle: assert property (@(posedge clk) disable iff (!arstN)
		!memWriteM |-> (byteEnM == 4'd0))
		else $error("byte enables active without a store");

	pcAligned: assert property (@(posedge clk) pcF[1:0] == 2'b00)
		else $error("fetch address not word aligned");

	// r0 writes are dropped before the trace
	noZeroWb: assert property (@(posedge clk) disable iff (!arstN)
		(debugWbRfWen != 4'd0) |-> (debugWbRfWnum != 5'd0))
		else $error("writeback reported to register zero");
endmodule

bind mipsCore mipsCoreAssertions u_assert (.*);

/* logic/mipsCore.sv */
`timescale 1ns/10ps

module mipsCore import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	output logic [31:0] pcF,
	input logic [31:0] instrF,
	output logic memWriteM,
	output logic [3:0] byteEnM,
	output logic [31:0] aluOutM,
	output logic [31:0] writeDataM,
	input logic [31:0] readDataM,
	output logic [31:0] debugWbPc,
	output logic [3:0] debugWbRfWen,
	output logic [4:0] debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);
	hazardIf hz();

	// decode
	instrWord instrD;
	logic [31:0] pcPlus4D;
	logic regWriteD;
	logic memWriteD;
	logic aluSrcD;
	logic regDstD;
	logic branchD;
	logic branchNeD;
	logic jumpD;
	logic jumpRegD;
	logic linkD;
	logic multD;
	logic storeByteD;
	aluOpE aluOpD;
	resultSrcE resultSrcD;
	logic [31:0] rd1D;
	logic [31:0] rd2D;
	logic [31:0] rsValD;
	logic [31:0] rtValD;
	logic [31:0] immD;
	logic [4:0] writeRegD;
	logic branchTakenD;
	// execute
	logic regWriteE;
	logic memWriteE;
	logic aluSrcE;
	logic multE;
	logic storeByteE;
	aluOpE aluCtrlE;
	resultSrcE resSrcE;
	logic [31:0] srcAE;
	logic [31:0] srcBE;
	logic [31:0] immE;
	logic [31:0] pcPlus4E;
	logic [4:0] rsE;
	logic [4:0] rtE;
	logic [4:0] writeRegE;
	logic [31:0] hiE;
	logic [31:0] loE;
	logic [31:0] aluOutE;
	logic [31:0] writeDataE;
	logic [31:0] exResE;
	logic [3:0] byteEnE;
	// memory
	logic regWriteM;
	logic loadM;
	logic [4:0] writeRegM;
	logic [31:0] pcPlus4M;
	// writeback
	logic regWriteW;
	logic loadW;
	logic [4:0] writeRegW;
	logic [31:0] aluOutW;
	logic [31:0] readDataW;
	logic [31:0] pcPlus4W;
	logic [31:0] resultW;
	logic wbEnW;

	//////////////////////////////////////////////////
	// fetch and decode
	//////////////////////////////////////////////////
	fetchUnit u_fetch (
		.clk(clk), .arstN(arstN), .stallF(hz.stallF), .stallD(hz.stallD),
		.branchTakenD(branchTakenD), .jumpD(jumpD), .jumpRegD(jumpRegD),
		.instrF(instrF), .rsValueD(rsValD), .pcF(pcF), .pcPlus4D(pcPlus4D),
		.instrD(instrD)
	);

	pipeControl u_ctrl (
		.clk(clk), .arstN(arstN), .instrD(instrD), .hz(hz.ctrl),
		.regWriteD(regWriteD), .memWriteD(memWriteD), .aluSrcD(aluSrcD),
		.regDstD(regDstD), .aluOpD(aluOpD), .resultSrcD(resultSrcD),
		.branchD(branchD), .branchNeD(branchNeD), .jumpD(jumpD),
		.jumpRegD(jumpRegD), .linkD(linkD), .multD(multD), .storeByteD(storeByteD)
	);

	regFile u_rf (
		.clk(clk), .we(wbEnW), .ra1(instrD.r.rs), .ra2(instrD.r.rt),
		.wa(writeRegW), .wd(resultW), .rd1(rd1D), .rd2(rd2D)
	);

	// ori zero-extends, everything else sign-extends
	assign immD = (instrD.i.op == opOri) ? {16'd0, instrD.i.imm}
		: {{16{instrD.i.imm[15]}}, instrD.i.imm};
	assign writeRegD = linkD ? 5'd31 : (regDstD ? instrD.r.rd : instrD.r.rt);

	// compare sees memory-stage results early
	assign rsValD = hz.fwdAD ? aluOutM : rd1D;
	assign rtValD = hz.fwdBD ? aluOutM : rd2D;
	assign branchTakenD = (branchD && (rsValD == rtValD))
		|| (branchNeD && (rsValD != rtValD));

	// stage info for hazard logic
	assign hz.rsD = instrD.r.rs;
	assign hz.rtD = instrD.r.rt;
	assign hz.branchD = branchD || branchNeD || jumpRegD;
	assign hz.rsE = rsE;
	assign hz.rtE = rtE;
	assign hz.writeRegE = writeRegE;
	assign hz.regWriteE = regWriteE;
	assign hz.loadE = (resSrcE == resMem);
	assign hz.writeRegM = writeRegM;
	assign hz.regWriteM = regWriteM;
	assign hz.loadM = loadM;
	assign hz.writeRegW = writeRegW;
	assign hz.regWriteW = regWriteW;

	//////////////////////////////////////////////////
	// decode/execute
	//////////////////////////////////////////////////
	// a stall turns the execute slot into a bubble
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteE <= 1'b0;
			memWriteE <= 1'b0;
			aluSrcE <= 1'b0;
			multE <= 1'b0;
			storeByteE <= 1'b0;
			aluCtrlE <= aluAdd;
			resSrcE <= resAlu;
		end else if (hz.flushE) begin
			regWriteE <= 1'b0;
			memWriteE <= 1'b0;
			aluSrcE <= 1'b0;
			multE <= 1'b0;
			storeByteE <= 1'b0;
			aluCtrlE <= aluAdd;
			resSrcE <= resAlu;
		end else begin
			regWriteE <= regWriteD;
			memWriteE <= memWriteD;
			aluSrcE <= aluSrcD;
			multE <= multD;
			storeByteE <= storeByteD;
			aluCtrlE <= aluOpD;
			resSrcE <= resultSrcD;
		end
	end

	always_ff @(posedge clk) begin
		srcAE <= rd1D;
		srcBE <= rd2D;
		immE <= immD;
		pcPlus4E <= pcPlus4D;
		rsE <= instrD.r.rs;
		rtE <= instrD.r.rt;
		writeRegE <= writeRegD;
	end

	executeUnit u_exec (
		.clk(clk), .arstN(arstN), .srcAE(srcAE), .srcBE(srcBE), .immE(immE),
		.fwdAE(hz.fwdAE), .fwdBE(hz.fwdBE), .resultM(aluOutM), .resultW(resultW),
		.aluSrcE(aluSrcE), .multE(multE), .storeByteE(storeByteE),
		.aluOpE(aluCtrlE), .hiE(hiE), .loE(loE), .aluOutE(aluOutE),
		.writeDataE(writeDataE), .byteEnE(byteEnE)
	);

	// one value leaves execute, also the memory address
	always_comb begin
		case (resSrcE)
			resHi: exResE = hiE;
			resLo: exResE = loE;
			resLink: exResE = pcPlus4E + 32'd4;
			default: exResE = aluOutE;
		endcase
	end

	//////////////////////////////////////////////////
	// execute/memory and memory/writeback
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteM <= 1'b0;
			memWriteM <= 1'b0;
			byteEnM <= 4'd0;
			loadM <= 1'b0;
			regWriteW <= 1'b0;
			loadW <= 1'b0;
		end else begin
			regWriteM <= regWriteE;
			memWriteM <= memWriteE;
			// lanes stay dark unless storing
			byteEnM <= memWriteE ? byteEnE : 4'd0;
			loadM <= (resSrcE == resMem);
			regWriteW <= regWriteM;
			loadW <= loadM;
		end
	end

	always_ff @(posedge clk) begin
		aluOutM <= exResE;
		writeDataM <= writeDataE;
		writeRegM <= writeRegE;
		pcPlus4M <= pcPlus4E;
		aluOutW <= aluOutM;
		readDataW <= readDataM;
		writeRegW <= writeRegM;
		pcPlus4W <= pcPlus4M;
	end

	assign resultW = loadW ? readDataW : aluOutW;
	// writes aimed at r0 are dropped and not reported
	assign wbEnW = regWriteW && (writeRegW != 5'd0);

	// debug trace
	assign debugWbPc = pcPlus4W - 32'd4;
	assign debugWbRfWen = {4{wbEnW}};
	assign debugWbRfWnum = writeRegW;
	assign debugWbRfWdata = resultW;
endmodule

/* logic/executeUnit.sv */
`timescale 1ns/10ps

module executeUnit import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input logic [31:0] srcAE,
	input logic [31:0] srcBE,
	input logic [31:0] immE,
	input fwdSelE fwdAE,
	input fwdSelE fwdBE,
	input logic [31:0] resultM,
	input logic [31:0] resultW,
	input logic aluSrcE,
	input logic multE,
	input logic storeByteE,
	input mipsPkg::aluOpE aluOpE,
	output logic [31:0] hiE,
	output logic [31:0] loE,
	output logic [31:0] aluOutE,
	output logic [31:0] writeDataE,
	output logic [3:0] byteEnE
);
	logic [31:0] regA;
	logic [31:0] regB;
	logic [31:0] opB;
	logic signed [63:0] product;

	//////////////////////////////////////////////////
	// operand select
	//////////////////////////////////////////////////
	always_comb begin
		case (fwdAE)
			fwdMem: regA = resultM;
			fwdWb: regA = resultW;
			default: regA = srcAE;
		endcase
		case (fwdBE)
			fwdMem: regB = resultM;
			fwdWb: regB = resultW;
			default: regB = srcBE;
		endcase
	end

	assign opB = aluSrcE ? immE : regB;

	// alu
	always_comb begin
		case (aluOpE)
			aluSub: aluOutE = regA - opB;
			aluAnd: aluOutE = regA & opB;
			aluOr: aluOutE = regA | opB;
			aluSlt: aluOutE = {31'd0, $signed(regA) < $signed(opB)};
			aluLui: aluOutE = {opB[15:0], 16'd0};
			default: aluOutE = regA + opB;
		endcase
	end

	//////////////////////////////////////////////////
	// hi/lo
	//////////////////////////////////////////////////
	// signed product of rs and rt
	assign product = $signed(regA) * $signed(regB);

	// written at the end of execute, so an mfhi right behind sees it
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			hiE <= 32'd0;
			loE <= 32'd0;
		end else if (multE) begin
			hiE <= product[63:32];
			loE <= product[31:0];
		end
	end

	// store lanes
	// sb puts the byte on every lane, the enable picks one
	assign writeDataE = storeByteE ? {4{regB[7:0]}} : regB;
	assign byteEnE = storeByteE ? (4'b0001 << aluOutE[1:0]) : 4'b1111;
endmodule

/* logic/regFile.sv */
`timescale 1ns/10ps

module regFile (
	input logic clk,
	input logic we,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	input logic [4:0] wa,
	input logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);
	logic [31:0] regs [1:31];

	// entry 0 has no storage
	always_ff @(posedge clk) begin
		if (we && (wa != 5'd0))
			regs[wa] <= wd;
	end

	// writeback and decode share a cycle, so pass new data straight through
	always_comb begin
		if (ra1 == 5'd0)
			rd1 = 32'd0;
		else if (we && (wa == ra1))
			rd1 = wd;
		else
			rd1 = regs[ra1];
		if (ra2 == 5'd0)
			rd2 = 32'd0;
		else if (we && (wa == ra2))
			rd2 = wd;
		else
			rd2 = regs[ra2];
	end
endmodule

/* logic/fetchUnit.sv */
`timescale 1ns/10ps

module fetchUnit import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input logic stallF,
	input logic stallD,
	input logic branchTakenD,
	input logic jumpD,
	input logic jumpRegD,
	input logic [31:0] instrF,
	input logic [31:0] rsValueD,
	output logic [31:0] pcF,
	output logic [31:0] pcPlus4D,
	output instrWord instrD
);
	logic [31:0] pcPlus4F;
	logic [31:0] branchTargetD;
	logic [31:0] jumpTargetD;
	logic [31:0] pcNextF;

	assign pcPlus4F = pcF + 32'd4;
	// offset counts words from the delay slot
	assign branchTargetD = pcPlus4D + {{14{instrD.i.imm[15]}}, instrD.i.imm, 2'b00};
	// 26-bit index within the delay slot's 256MB region
	assign jumpTargetD = {pcPlus4D[31:28], instrD.i.rs, instrD.i.rt, instrD.i.imm, 2'b00};

	// decode redirects, fetch of the delay slot is already under way
	always_comb begin
		if (jumpRegD)
			pcNextF = rsValueD;
		else if (jumpD)
			pcNextF = jumpTargetD;
		else if (branchTakenD)
			pcNextF = branchTargetD;
		else
			pcNextF = pcPlus4F;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			pcF <= 32'd0;
		else if (!stallF)
			pcF <= pcNextF;
	end

	// fetch/decode register, never flushed
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			instrD <= '0;
		else if (!stallD)
			instrD <= instrF;
	end

	always_ff @(posedge clk) begin
		if (!stallD)
			pcPlus4D <= pcPlus4F;
	end
endmodule

/* logic/pipeControl.sv */
`timescale 1ns/10ps

module pipeControl import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input instrWord instrD,
	hazardIf.ctrl hz,
	output logic regWriteD,
	output logic memWriteD,
	output logic aluSrcD,
	output logic regDstD,
	output aluOpE aluOpD,
	output resultSrcE resultSrcD,
	output logic branchD,
	output logic branchNeD,
	output logic jumpD,
	output logic jumpRegD,
	output logic linkD,
	output logic multD,
	output logic storeByteD
);
	logic usesRsD;
	logic usesRtD;
	logic rsHitE;
	logic rtHitE;
	logic rsHitM;
	logic rtHitM;
	logic useStall;
	logic branchStall;
	// destination of the load now in memory, zero when none
	logic [4:0] loadDstQ;

	//////////////////////////////////////////////////
	// instruction decode
	//////////////////////////////////////////////////
	always_comb begin
		regWriteD = 1'b0;
		memWriteD = 1'b0;
		aluSrcD = 1'b0;
		regDstD = 1'b0;
		aluOpD = aluAdd;
		resultSrcD = resAlu;
		branchD = 1'b0;
		branchNeD = 1'b0;
		jumpD = 1'b0;
		jumpRegD = 1'b0;
		linkD = 1'b0;
		multD = 1'b0;
		storeByteD = 1'b0;
		usesRsD = 1'b1;
		usesRtD = 1'b0;
		case (instrD.r.op)
			opRType: begin
				// most R-types write rd, mult and jr clear it below
				regWriteD = 1'b1;
				regDstD = 1'b1;
				usesRtD = 1'b1;
				case (instrD.r.funct)
					fnAddu: aluOpD = aluAdd;
					fnSubu: aluOpD = aluSub;
					fnAnd: aluOpD = aluAnd;
					fnOr: aluOpD = aluOr;
					fnSlt: aluOpD = aluSlt;
					fnMfhi: resultSrcD = resHi;
					fnMflo: resultSrcD = resLo;
					fnMult: begin
						regWriteD = 1'b0;
						multD = 1'b1;
					end
					fnJr: begin
						regWriteD = 1'b0;
						jumpRegD = 1'b1;
					end
					// sll-encoded nop and anything unknown
					default: regWriteD = 1'b0;
				endcase
			end
			opAddiu, opOri, opLui, opLw: begin
				regWriteD = 1'b1;
				aluSrcD = 1'b1;
				if (instrD.i.op == opOri)
					aluOpD = aluOr;
				if (instrD.i.op == opLui)
					aluOpD = aluLui;
				if (instrD.i.op == opLw)
					resultSrcD = resMem;
			end
			opSw, opSb: begin
				memWriteD = 1'b1;
				aluSrcD = 1'b1;
				usesRtD = 1'b1;
				storeByteD = (instrD.i.op == opSb);
			end
			opBeq, opBne: begin
				branchD = (instrD.i.op == opBeq);
				branchNeD = (instrD.i.op == opBne);
				usesRtD = 1'b1;
			end
			opJ, opJal: begin
				// rs and rt bits are part of the jump index here
				jumpD = 1'b1;
				usesRsD = 1'b0;
				linkD = (instrD.i.op == opJal);
				regWriteD = (instrD.i.op == opJal);
				if (instrD.i.op == opJal)
					resultSrcD = resLink;
			end
			default: usesRsD = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////
	// stalls
	//////////////////////////////////////////////////
	assign rsHitE = usesRsD && hz.regWriteE && (hz.writeRegE != 5'd0)
		&& (hz.writeRegE == hz.rsD);
	assign rtHitE = usesRtD && hz.regWriteE && (hz.writeRegE != 5'd0)
		&& (hz.writeRegE == hz.rtD);
	assign rsHitM = usesRsD && (loadDstQ != 5'd0) && (loadDstQ == hz.rsD);
	assign rtHitM = usesRtD && (loadDstQ != 5'd0) && (loadDstQ == hz.rtD);

	// load-use, one bubble
	assign useStall = hz.loadE && (rsHitE || rtHitE);
	// branch compare in decode needs the value a cycle earlier
	// load data never forwards into decode, so wait till writeback
	assign branchStall = hz.branchD && (rsHitE || rtHitE || rsHitM || rtHitM);

	assign hz.stallF = useStall || branchStall;
	assign hz.stallD = useStall || branchStall;
	assign hz.flushE = useStall || branchStall;

	// execute never stalls, so the load simply moves on each edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			loadDstQ <= 5'd0;
		else if (hz.loadE && hz.regWriteE)
			loadDstQ <= hz.writeRegE;
		else
			loadDstQ <= 5'd0;
	end

	//////////////////////////////////////////////////
	// forwarding
	//////////////////////////////////////////////////
	// memory result only, writeback goes through the regfile bypass
	assign hz.fwdAD = hz.regWriteM && !hz.loadM && (hz.writeRegM != 5'd0)
		&& (hz.writeRegM == hz.rsD);
	assign hz.fwdBD = hz.regWriteM && !hz.loadM && (hz.writeRegM != 5'd0)
		&& (hz.writeRegM == hz.rtD);

	// youngest producer wins
	function automatic fwdSelE pickFwd(input logic [4:0] src);
		if (hz.regWriteM && (hz.writeRegM != 5'd0) && (hz.writeRegM == src))
			return fwdMem;
		if (hz.regWriteW && (hz.writeRegW != 5'd0) && (hz.writeRegW == src))
			return fwdWb;
		return fwdRf;
	endfunction

	assign hz.fwdAE = pickFwd(hz.rsE);
	assign hz.fwdBE = pickFwd(hz.rtE);
endmodule

/* logic/hazardIf.sv */
`timescale 1ns/10ps

interface hazardIf import mipsPkg::*; ();
	// source addresses
	logic [4:0] rsD;
	logic [4:0] rtD;
	logic [4:0] rsE;
	logic [4:0] rtE;
	// destinations per stage
	logic [4:0] writeRegE;
	logic [4:0] writeRegM;
	logic [4:0] writeRegW;
	logic regWriteE;
	logic regWriteM;
	logic regWriteW;
	logic loadE;
	logic loadM;
	// beq, bne or jr sitting in decode
	logic branchD;
	// answers from control
	logic stallF;
	logic stallD;
	logic flushE;
	logic fwdAD;
	logic fwdBD;
	fwdSelE fwdAE;
	fwdSelE fwdBE;

	modport pipe(
		output rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW,
		output regWriteE, regWriteM, regWriteW, loadE, loadM, branchD,
		input stallF, stallD, flushE, fwdAD, fwdBD, fwdAE, fwdBE
	);

	modport ctrl(
		input rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW,
		input regWriteE, regWriteM, regWriteW, loadE, loadM, branchD,
		output stallF, stallD, flushE, fwdAD, fwdBD, fwdAE, fwdBE
	);
endinterface

/* logic/mipsPkg.sv */
package mipsPkg;

	//////////////////////////////////////////////////
	// opcodes
	//////////////////////////////////////////////////
	localparam logic [5:0] opRType = 6'b000000;
	localparam logic [5:0] opJ     = 6'b000010;
	localparam logic [5:0] opJal   = 6'b000011;
	localparam logic [5:0] opBeq   = 6'b000100;
	localparam logic [5:0] opBne   = 6'b000101;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opOri   = 6'b001101;
	localparam logic [5:0] opLui   = 6'b001111;
	localparam logic [5:0] opLw    = 6'b100011;
	localparam logic [5:0] opSb    = 6'b101000;
	localparam logic [5:0] opSw    = 6'b101011;

	// function codes, R-type only
	localparam logic [5:0] fnJr   = 6'b001000;
	localparam logic [5:0] fnMfhi = 6'b010000;
	localparam logic [5:0] fnMflo = 6'b010010;
	localparam logic [5:0] fnMult = 6'b011000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd  = 6'b100100;
	localparam logic [5:0] fnOr   = 6'b100101;
	localparam logic [5:0] fnSlt  = 6'b101010;

	//////////////////////////////////////////////////
	// control encodings
	//////////////////////////////////////////////////
	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpE;

	// what the execute stage hands on as the instruction result
	typedef enum logic [2:0] {resAlu, resMem, resHi, resLo, resLink} resultSrcE;

	typedef enum logic [1:0] {fwdRf, fwdMem, fwdWb} fwdSelE;

	// register-format view
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFieldsT;

	// immediate-format view, low 26 bits double as jump index
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iFieldsT;

	typedef union packed {
		rFieldsT r;
		iFieldsT i;
	} instrWord;

endpackage
